//--- Bender.yml
package:
  name: dfp_mul

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dfpPkg.sv
      - dfpDecode.sv
      - bcdMulSerial.sv
      - dfpRound.sv
      - dfpMulTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - dfpMulTb.sv

//--- bcdMulSerial.sv
`timescale 1ns/1ps
`include "dfpMul_params.svh"

module bcdMulSerial (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic [`DFP_COEF_W-1:0] coefA,
	input  logic [`DFP_COEF_W-1:0] coefB,
	output logic [`DFP_PROD_W-1:0] product,
	output logic prodValid
);

	logic running;
	// running sum of the partial products
	logic [`DFP_PROD_W-1:0] acc;
	// coefA aligned to the current multiplier digit
	logic [`DFP_PROD_W-1:0] mcand;
	// multiplier, current digit in the low nibble
	logic [`DFP_COEF_W-1:0] mulReg;
	// additions left for the current digit
	logic [3:0] cnt;
	logic [2:0] digIdx;
	logic lastDigit;

	// ----------------------------------------------------------------------
	// decimal helpers
	// ----------------------------------------------------------------------

	// digit-wise add with decimal adjust, top carry cannot occur
	function automatic logic [`DFP_PROD_W-1:0] bcdAdd(
		input logic [`DFP_PROD_W-1:0] x,
		input logic [`DFP_PROD_W-1:0] y
	);
		logic [4:0] s;
		logic c;
		logic [`DFP_PROD_W-1:0] r;
		c = 1'b0;
		r = '0;
		for (int i = 0; i < `DFP_PROD_DIGITS; i++) begin
			s = {1'b0, x[4*i +: 4]} + {1'b0, y[4*i +: 4]} + {4'b0, c};
			if (s > 5'd9) begin
				// +6 skips the six unused nibble codes
				r[4*i +: 4] = s[3:0] + 4'd6;
				c = 1'b1;
			end else begin
				r[4*i +: 4] = s[3:0];
				c = 1'b0;
			end
		end
		return r;
	endfunction

	function automatic logic isBcd(input logic [`DFP_PROD_W-1:0] x);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `DFP_PROD_DIGITS; i++) begin
			if (x[4*i +: 4] > 4'd9)
				ok = 1'b0;
		end
		return ok;
	endfunction

	// ----------------------------------------------------------------------
	// sequencing
	// ----------------------------------------------------------------------

	assign lastDigit = (digIdx == 3'(`DFP_DIGITS - 1));

	// per digit: one add per unit of digit value, then one shift step
	// the shift step of the top digit ends the multiply instead
	always_ff @(posedge clk) begin
		if (!rstN) begin
			running <= 1'b0;
			prodValid <= 1'b0;
			cnt <= '0;
			digIdx <= '0;
		end else begin
			prodValid <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt <= coefB[3:0];
				digIdx <= '0;
			end else if (running) begin
				if (cnt != 4'd0) begin
					cnt <= cnt - 4'd1;
				end else if (lastDigit) begin
					running <= 1'b0;
					prodValid <= 1'b1;
				end else begin
					// next digit count comes from above the current one
					cnt <= mulReg[7:4];
					digIdx <= digIdx + 3'd1;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (start) begin
			acc <= '0;
			mcand <= {{(`DFP_PROD_W - `DFP_COEF_W){1'b0}}, coefA};
			mulReg <= coefB;
		end else if (running) begin
			if (cnt != 4'd0) begin
				acc <= bcdAdd(acc, mcand);
			end else if (!lastDigit) begin
				// one decimal place up for the next multiplier digit
				mcand <= mcand << 4;
				mulReg <= mulReg >> 4;
			end
		end
	end

	// acc is complete and stable from prodValid on
	assign product = acc;

	startWhileRunning: assert property (@(posedge clk) disable iff (!rstN)
		start |-> !running)
		else $error("start received while a multiply is running");

	accDigitRange: assert property (@(posedge clk) disable iff (!rstN)
		running |=> isBcd(acc))
		else $error("accumulator holds a digit above 9");

endmodule

//--- dfpDecode.sv
`timescale 1ns/1ps
`include "dfpMul_params.svh"

module dfpDecode (
	input  logic clk,
	input  logic rstN,
	input  logic ld,
	input  dfpPkg::dfpWord a,
	input  dfpPkg::dfpWord b,
	input  dfpPkg::roundMode rm,
	input  logic finish,
	output logic start,
	output logic busy,
	output logic [`DFP_COEF_W-1:0] coefA,
	output logic [`DFP_COEF_W-1:0] coefB,
	output logic signed [`DFP_ESUM_W-1:0] expSum,
	output logic signOut,
	output dfpPkg::dfpSpecial special,
	output logic [`DFP_PAYLOAD_W-1:0] nanPayload,
	output logic invalidIn,
	output dfpPkg::roundMode rmQ
);

	dfpPkg::dfpClass clsA, clsB;
	logic aNaN, bNaN, aInf, bInf, aZero, bZero;
	dfpPkg::dfpSpecial specialNext;
	logic [`DFP_PAYLOAD_W-1:0] payloadNext;
	logic invalidNext;

	// exponent field all ones selects the special view
	function automatic dfpPkg::dfpClass classify(input dfpPkg::dfpWord w);
		if (w.fin.exp == '1) begin
			case (w.spc.kind)
				2'b10: return dfpPkg::clsQNaN;
				2'b11: return dfpPkg::clsSNaN;
				// unused kind 01 reads as infinity
				default: return dfpPkg::clsInf;
			endcase
		end
		if (w.fin.coef == '0)
			return dfpPkg::clsZero;
		return dfpPkg::clsFinite;
	endfunction

	assign clsA = classify(a);
	assign clsB = classify(b);
	assign aNaN = (clsA == dfpPkg::clsQNaN) || (clsA == dfpPkg::clsSNaN);
	assign bNaN = (clsB == dfpPkg::clsQNaN) || (clsB == dfpPkg::clsSNaN);
	assign aInf = (clsA == dfpPkg::clsInf);
	assign bInf = (clsB == dfpPkg::clsInf);
	assign aZero = (clsA == dfpPkg::clsZero);
	assign bZero = (clsB == dfpPkg::clsZero);

	// special result, highest priority first
	always_comb begin
		specialNext = dfpPkg::spNone;
		payloadNext = '0;
		invalidNext = 1'b0;
		if (aNaN || bNaN) begin
			// a's payload wins, any sNaN is invalid
			specialNext = dfpPkg::spQNaN;
			payloadNext = aNaN ? a.spc.payload : b.spc.payload;
			invalidNext = (clsA == dfpPkg::clsSNaN) || (clsB == dfpPkg::clsSNaN);
		end else if ((aInf && bZero) || (bInf && aZero)) begin
			specialNext = dfpPkg::spQNaN;
			invalidNext = 1'b1;
		end else if (aInf || bInf) begin
			specialNext = dfpPkg::spInf;
		end else if (aZero || bZero) begin
			specialNext = dfpPkg::spZero;
		end
	end

	// start strobe and busy level
	always_ff @(posedge clk) begin
		if (!rstN) begin
			start <= 1'b0;
			busy <= 1'b0;
		end else begin
			start <= ld;
			if (ld)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
		end
	end

	// operand fields, held until the next ld
	always_ff @(posedge clk) begin
		if (ld) begin
			// non-finite coefficients are zeroed so the multiplier sees clean BCD
			coefA <= (clsA == dfpPkg::clsFinite) ? a.fin.coef : '0;
			coefB <= (clsB == dfpPkg::clsFinite) ? b.fin.coef : '0;
			expSum <= $signed({2'b00, a.fin.exp}) + $signed({2'b00, b.fin.exp})
				- `DFP_ESUM_W'(`DFP_BIAS);
			signOut <= a.fin.sign ^ b.fin.sign;
			special <= specialNext;
			nanPayload <= payloadNext;
			invalidIn <= invalidNext;
			rmQ <= rm;
		end
	end

	// busy only drops on done from the result stage
	ldWhileBusy: assert property (@(posedge clk) disable iff (!rstN) ld |-> !busy)
		else $error("ld asserted while a multiply is in flight");

endmodule

//--- dfpMulTb.sv
`timescale 1ns/1ps
`include "dfpMul_params.svh"

module dfpMulTb;

	localparam int numDirected = 18;
	localparam int numRandom = 40;
	// worst op is about 65 cycles plus up to 3 idle ones
	localparam int timeoutCycles = 70 * (numDirected + numRandom) + 50;

	logic clk;
	logic rstN;
	logic ld;
	dfpPkg::dfpWord a, b, o;
	dfpPkg::roundMode rm;
	logic invalid, overflow, underflow, inexact, done, busy;

	// expected result of the op in flight
	dfpPkg::dfpWord expO;
	logic expInv, expOvf, expUnf, expInx;

	logic [31:0] lfsrState = 32'hcb4c291f;
	int errors = 0;
	int opCount = 0;
	int cycles = 0;
	logic pending = 1'b0;
	logic everLd = 1'b0;
	logic seenDone = 1'b0;

	dfpMulTop i_dfpMulTop (
		.clk(clk),
		.rstN(rstN),
		.ld(ld),
		.a(a),
		.b(b),
		.rm(rm),
		.o(o),
		.invalid(invalid),
		.overflow(overflow),
		.underflow(underflow),
		.inexact(inexact),
		.done(done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// random source and operand builders
	// ----------------------------------------------------------------------

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	function automatic dfpPkg::dfpWord makeFinite(input logic s, input int e, input int c);
		dfpPkg::dfpWord w;
		w.fin.sign = s;
		w.fin.exp = 7'(e);
		w.fin.coef = 24'(c);
		return w;
	endfunction

	function automatic dfpPkg::dfpWord makeSpecial(input logic s, input logic [1:0] k,
		input int p);
		dfpPkg::dfpWord w;
		w.spc.sign = s;
		w.spc.marker = '1;
		w.spc.kind = k;
		w.spc.payload = 22'(p);
		return w;
	endfunction

	// exponent 32..95 keeps most sums in range
	// nibbles above 9 are redrawn
	task automatic randomOperand(output dfpPkg::dfpWord w);
		logic [31:0] v;
		w = '0;
		drawBits(1, v);
		w.fin.sign = v[0];
		drawBits(6, v);
		w.fin.exp = 7'd32 + 7'(v[5:0]);
		for (int i = 0; i < `DFP_DIGITS; i++) begin
			do
				drawBits(4, v);
			while (v[3:0] > 4'd9);
			w.fin.coef[4*i +: 4] = v[3:0];
		end
	endtask

	task automatic randomMode(output dfpPkg::roundMode m);
		logic [31:0] v;
		do
			drawBits(2, v);
		while (v[1:0] == 2'd3);
		m = dfpPkg::roundMode'(v[1:0]);
	endtask

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	function automatic longint bcdToInt(input logic [`DFP_COEF_W-1:0] c);
		longint r;
		r = 0;
		for (int i = `DFP_DIGITS - 1; i >= 0; i--)
			r = r * 10 + c[4*i +: 4];
		return r;
	endfunction

	function automatic logic [`DFP_COEF_W-1:0] intToBcd(input longint n);
		logic [`DFP_COEF_W-1:0] r;
		for (int i = 0; i < `DFP_DIGITS; i++) begin
			r[4*i +: 4] = 4'(n % 10);
			n = n / 10;
		end
		return r;
	endfunction

	// returns {word, invalid, overflow, underflow, inexact}
	function automatic logic [35:0] expectedResult(input dfpPkg::dfpWord x,
		input dfpPkg::dfpWord y, input dfpPkg::roundMode m);
		dfpPkg::dfpWord r;
		logic inv, ovf, unf, inx;
		logic xNaN, yNaN, xInf, yInf, xZero, yZero;
		longint prod, div, kept, dropped;
		int shift, e, esum;
		r = '0;
		inv = 1'b0;
		ovf = 1'b0;
		unf = 1'b0;
		inx = 1'b0;
		xNaN = (x.fin.exp == 7'h7f) && x.spc.kind[1];
		yNaN = (y.fin.exp == 7'h7f) && y.spc.kind[1];
		xInf = (x.fin.exp == 7'h7f) && !x.spc.kind[1];
		yInf = (y.fin.exp == 7'h7f) && !y.spc.kind[1];
		xZero = (x.fin.exp != 7'h7f) && (x.fin.coef == 0);
		yZero = (y.fin.exp != 7'h7f) && (y.fin.coef == 0);
		esum = int'(x.fin.exp) + int'(y.fin.exp) - `DFP_BIAS;
		if (xNaN || yNaN) begin
			r = makeSpecial(1'b0, 2'b10, xNaN ? int'(x.spc.payload) : int'(y.spc.payload));
			inv = (xNaN && x.spc.kind[0]) || (yNaN && y.spc.kind[0]);
		end else if ((xInf && yZero) || (yInf && xZero)) begin
			r = makeSpecial(1'b0, 2'b10, 0);
			inv = 1'b1;
		end else if (xInf || yInf) begin
			r = makeSpecial(1'b0, 2'b00, 0);
		end else if (xZero || yZero) begin
			r.fin.exp = (esum < 0) ? 7'd0 : (esum > `DFP_EXP_MAX) ? 7'd126 : 7'(esum);
		end else begin
			prod = bcdToInt(x.fin.coef) * bcdToInt(y.fin.coef);
			div = 1;
			shift = 0;
			while (prod / div > 999999) begin
				div = div * 10;
				shift++;
			end
			kept = prod / div;
			dropped = prod % div;
			inx = (dropped != 0);
			// div/2 is the value of a lone 5 in the first dropped place
			if (shift > 0) begin
				if (m == dfpPkg::rmHalfUp && dropped >= div / 2)
					kept++;
				if (m == dfpPkg::rmHalfEven && (dropped > div / 2
					|| (dropped == div / 2 && kept % 2 == 1)))
					kept++;
			end
			if (kept > 999999) begin
				kept = kept / 10;
				shift++;
			end
			e = esum + shift;
			if (e > `DFP_EXP_MAX) begin
				r = makeSpecial(1'b0, 2'b00, 0);
				ovf = 1'b1;
				inx = 1'b1;
			end else if (e < 0) begin
				unf = 1'b1;
				inx = 1'b1;
			end else begin
				r.fin.exp = 7'(e);
				r.fin.coef = intToBcd(kept);
			end
		end
		// sign is always the XOR of the operand signs
		r.fin.sign = x.fin.sign ^ y.fin.sign;
		return {r, inv, ovf, unf, inx};
	endfunction

	// ----------------------------------------------------------------------
	// one multiply is an ld strobe then a wait for done
	// ----------------------------------------------------------------------

	task automatic runOp(input dfpPkg::dfpWord x, input dfpPkg::dfpWord y,
		input dfpPkg::roundMode m);
		logic [35:0] ex;
		ex = expectedResult(x, y, m);
		@(posedge clk);
		#2;
		a = x;
		b = y;
		rm = m;
		ld = 1'b1;
		{expO, expInv, expOvf, expUnf, expInx} = ex;
		opCount++;
		@(posedge clk);
		#2;
		ld = 1'b0;
		while (!done) begin
			@(posedge clk);
			#2;
		end
	endtask

	// ----------------------------------------------------------------------
	// bookkeeping and timeout
	// ----------------------------------------------------------------------

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (ld)
			everLd <= 1'b1;
		if (done)
			seenDone <= 1'b1;
		if (!rstN)
			pending <= 1'b0;
		else if (ld)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
		if (cycles >= timeoutCycles) begin
			$display("timeout after %0d cycles, done never came back", cycles);
			$display("ops %0d, errors %0d", opCount, errors + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	checkWord: assert property (@(posedge clk) disable iff (!rstN) done |-> o == expO)
		else begin
			errors++;
			$display("MISMATCH o got %h expected %h", $sampled(o), $sampled(expO));
		end
	checkInvalid: assert property (@(posedge clk) disable iff (!rstN)
		done |-> invalid == expInv)
		else begin
			errors++;
			$display("MISMATCH invalid got %h expected %h", $sampled(invalid), $sampled(expInv));
		end
	checkOverflow: assert property (@(posedge clk) disable iff (!rstN)
		done |-> overflow == expOvf)
		else begin
			errors++;
			$display("MISMATCH overflow got %h expected %h", $sampled(overflow),
				$sampled(expOvf));
		end
	checkUnderflow: assert property (@(posedge clk) disable iff (!rstN)
		done |-> underflow == expUnf)
		else begin
			errors++;
			$display("MISMATCH underflow got %h expected %h", $sampled(underflow),
				$sampled(expUnf));
		end
	checkInexact: assert property (@(posedge clk) disable iff (!rstN)
		done |-> inexact == expInx)
		else begin
			errors++;
			$display("MISMATCH inexact got %h expected %h", $sampled(inexact), $sampled(expInx));
		end

	// protocol
	busyRise: assert property (@(posedge clk) disable iff (!rstN) ld |=> busy)
		else begin
			errors++;
			$display("busy did not rise the cycle after ld");
		end
	busyFall: assert property (@(posedge clk) disable iff (!rstN) done |-> busy ##1 !busy)
		else begin
			errors++;
			$display("busy did not fall together with done");
		end
	doneSingle: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
		else begin
			errors++;
			$display("done lasted more than one cycle");
		end
	donePending: assert property (@(posedge clk) disable iff (!rstN) done |-> pending)
		else begin
			errors++;
			$display("done pulsed with no multiply pending");
		end
	outputHold: assert property (@(posedge clk) disable iff (!rstN)
		seenDone && !done |-> $stable(o)
			&& $stable({invalid, overflow, underflow, inexact}))
		else begin
			errors++;
			$display("result or flags changed between done pulses");
		end
	// outputs are unknown before the first reset edge
	idleAfterReset: assert property (@(posedge clk) cycles > 0 && !everLd |-> !done && !busy)
		else begin
			errors++;
			$display("done or busy high before the first ld");
		end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	initial begin
		dfpPkg::dfpWord x, y;
		dfpPkg::roundMode m;
		logic [31:0] gap;
		rstN = 1'b0;
		ld = 1'b0;
		a = '0;
		b = '0;
		rm = dfpPkg::rmTrunc;
		expO = '0;
		{expInv, expOvf, expUnf, expInx} = '0;
		repeat (10) @(posedge clk);
		#2;
		rstN = 1'b1;
		repeat (3) @(posedge clk);

		// specials in priority order
		runOp(makeSpecial(0, 2'b00, 0), makeFinite(0, 40, 0), dfpPkg::rmTrunc);
		runOp(makeSpecial(1, 2'b11, 'h12345), makeFinite(0, 70, 'h000321), dfpPkg::rmHalfUp);
		runOp(makeSpecial(0, 2'b10, 'h2aaaa), makeSpecial(1, 2'b11, 'h15555), dfpPkg::rmTrunc);
		runOp(makeFinite(0, 60, 'h004567), makeSpecial(0, 2'b10, 'h3abcd), dfpPkg::rmTrunc);
		runOp(makeFinite(1, 60, 'h000123), makeSpecial(0, 2'b00, 0), dfpPkg::rmHalfEven);
		// zero clamps low and high
		runOp(makeFinite(0, 10, 0), makeFinite(1, 20, 'h001234), dfpPkg::rmTrunc);
		runOp(makeFinite(1, 120, 'h000077), makeFinite(0, 110, 0), dfpPkg::rmHalfUp);
		// exponent range
		runOp(makeFinite(0, 126, 'h999999), makeFinite(0, 126, 'h999999), dfpPkg::rmTrunc);
		runOp(makeFinite(1, 0, 'h123456), makeFinite(0, 0, 'h000002), dfpPkg::rmTrunc);
		// ties 1500015 keeps an odd digit and 1500045 an even one
		for (int i = 0; i < 3; i++) begin
			runOp(makeFinite(0, 50, 'h100001), makeFinite(0, 50, 'h000015),
				dfpPkg::roundMode'(i));
			runOp(makeFinite(1, 50, 'h100003), makeFinite(0, 50, 'h000015),
				dfpPkg::roundMode'(i));
		end
		// 9999996 rounds up past six digits
		runOp(makeFinite(0, 40, 'h833333), makeFinite(0, 40, 'h000012), dfpPkg::rmHalfUp);
		// 10000000 drops only zeros and stays exact
		runOp(makeFinite(0, 50, 'h250000), makeFinite(1, 50, 'h000040), dfpPkg::rmHalfEven);
		// 30315251 is above the tie only through the lower dropped digit
		runOp(makeFinite(0, 50, 'h300151), makeFinite(0, 50, 'h000101), dfpPkg::rmHalfEven);

		// random ops with short idle gaps so the hold check sees quiet cycles
		for (int i = 0; i < numRandom; i++) begin
			randomOperand(x);
			randomOperand(y);
			randomMode(m);
			runOp(x, y, m);
			drawBits(2, gap);
			repeat (gap[1:0]) @(posedge clk);
		end

		repeat (4) @(posedge clk);
		$display("ops %0d, errors %0d", opCount, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- dfpMulTop.sv
`timescale 1ns/1ps
`include "dfpMul_params.svh"

module dfpMulTop (
	input  logic clk,
	input  logic rstN,
	input  logic ld,
	input  dfpPkg::dfpWord a,
	input  dfpPkg::dfpWord b,
	input  dfpPkg::roundMode rm,
	output dfpPkg::dfpWord o,
	output logic invalid,
	output logic overflow,
	output logic underflow,
	output logic inexact,
	output logic done,
	output logic busy
);

	// ----------------------------------------------------------------------
	// decode to execute and result
	// ----------------------------------------------------------------------

	logic start;
	logic [`DFP_COEF_W-1:0] coefA, coefB;
	logic signed [`DFP_ESUM_W-1:0] expSum;
	logic signOut;
	dfpPkg::dfpSpecial special;
	logic [`DFP_PAYLOAD_W-1:0] nanPayload;
	logic invalidIn;
	dfpPkg::roundMode rmQ;

	// execute to result
	logic prodValid;
	logic [`DFP_PROD_W-1:0] product;

	// done also clears busy in decode
	dfpDecode uDecode (
		.clk(clk),
		.rstN(rstN),
		.ld(ld),
		.a(a),
		.b(b),
		.rm(rm),
		.finish(done),
		.start(start),
		.busy(busy),
		.coefA(coefA),
		.coefB(coefB),
		.expSum(expSum),
		.signOut(signOut),
		.special(special),
		.nanPayload(nanPayload),
		.invalidIn(invalidIn),
		.rmQ(rmQ)
	);

	// variable latency digit-serial product
	bcdMulSerial uMul (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.coefA(coefA),
		.coefB(coefB),
		.product(product),
		.prodValid(prodValid)
	);

	dfpRound uRound (
		.clk(clk),
		.rstN(rstN),
		.prodValid(prodValid),
		.product(product),
		.expSum(expSum),
		.signOut(signOut),
		.special(special),
		.nanPayload(nanPayload),
		.invalidIn(invalidIn),
		.rmQ(rmQ),
		.o(o),
		.invalid(invalid),
		.overflow(overflow),
		.underflow(underflow),
		.inexact(inexact),
		.done(done)
	);

endmodule

//--- dfpMul_params.svh
`ifndef DFP_MUL_PARAMS_SVH
`define DFP_MUL_PARAMS_SVH

// ----------------------------------------------------------------------
// word format
// ----------------------------------------------------------------------

// digits in the coefficient of one operand
`define DFP_DIGITS 6
// biased exponent field
`define DFP_EXP_W 7
// value = coef * 10^(exp - bias)
`define DFP_BIAS 63
// largest finite exponent; all ones marks inf/NaN
`define DFP_EXP_MAX 126
// NaN payload field of the special view
`define DFP_PAYLOAD_W 22

// ----------------------------------------------------------------------
// derived widths
// ----------------------------------------------------------------------

// full product of two coefficients
`define DFP_PROD_DIGITS 12
`define DFP_COEF_W (`DFP_DIGITS * 4)
`define DFP_PROD_W (`DFP_PROD_DIGITS * 4)
// exponent sum minus bias, signed, two guard bits
`define DFP_ESUM_W (`DFP_EXP_W + 2)

`endif

//--- dfpPkg.sv
`include "dfpMul_params.svh"

package dfpPkg;

	// ----------------------------------------------------------------------
	// operand word, two views
	// ----------------------------------------------------------------------

	// finite number: sign, biased exponent, six BCD digits
	typedef struct packed {
		logic sign;
		logic [`DFP_EXP_W-1:0] exp;
		logic [`DFP_COEF_W-1:0] coef;
	} dfpFinite;

	// special: exponent field all ones, then kind and payload
	// kind 00 inf, 10 quiet NaN, 11 signalling NaN
	typedef struct packed {
		logic sign;
		logic [`DFP_EXP_W-1:0] marker;
		logic [1:0] kind;
		logic [`DFP_PAYLOAD_W-1:0] payload;
	} dfpSpecView;

	// the marker overlays fin.exp exactly
	typedef union packed {
		dfpFinite fin;
		dfpSpecView spc;
	} dfpWord;

	// ----------------------------------------------------------------------
	// classification and prediction
	// ----------------------------------------------------------------------

	typedef enum logic [2:0] {
		clsZero,
		clsFinite,
		clsInf,
		clsQNaN,
		clsSNaN
	} dfpClass;

	// special result known right after decode
	typedef enum logic [1:0] {
		spNone,
		spInf,
		spQNaN,
		spZero
	} dfpSpecial;

	typedef enum logic [1:0] {
		rmTrunc,
		rmHalfUp,
		rmHalfEven
	} roundMode;

endpackage

//--- dfpRound.sv
`timescale 1ns/1ps
`include "dfpMul_params.svh"

module dfpRound (
	input  logic clk,
	input  logic rstN,
	input  logic prodValid,
	input  logic [`DFP_PROD_W-1:0] product,
	input  logic signed [`DFP_ESUM_W-1:0] expSum,
	input  logic signOut,
	input  dfpPkg::dfpSpecial special,
	input  logic [`DFP_PAYLOAD_W-1:0] nanPayload,
	input  logic invalidIn,
	input  dfpPkg::roundMode rmQ,
	output dfpPkg::dfpWord o,
	output logic invalid,
	output logic overflow,
	output logic underflow,
	output logic inexact,
	output logic done
);

	logic [3:0] sigDigits;
	logic [2:0] shift;
	logic [`DFP_PROD_W-1:0] shifted;
	logic [`DFP_COEF_W-1:0] kept;
	logic [3:0] firstDrop;
	logic restNz;
	logic dropNz;
	logic roundUp;
	logic [`DFP_COEF_W-1:0] incSum;
	logic incCarry;
	logic [`DFP_COEF_W-1:0] coefOut;
	logic [2:0] shiftTot;
	logic signed [`DFP_ESUM_W:0] expAdj;
	logic [`DFP_EXP_W-1:0] zeroExp;
	dfpPkg::dfpWord oNext;
	logic invNext, ovfNext, unfNext, inxNext;

	// ----------------------------------------------------------------------
	// alignment to six digits
	// ----------------------------------------------------------------------

	// significant digits = index of top nonzero digit plus one
	always_comb begin
		sigDigits = '0;
		for (int i = 0; i < `DFP_PROD_DIGITS; i++) begin
			if (product[4*i +: 4] != 4'd0)
				sigDigits = 4'(i + 1);
		end
	end

	assign shift = (sigDigits > `DFP_DIGITS) ? 3'(sigDigits - `DFP_DIGITS) : 3'd0;
	assign shifted = product >> (4 * shift);
	assign kept = shifted[`DFP_COEF_W-1:0];

	// first dropped digit and sticky of the ones below it
	always_comb begin
		firstDrop = 4'd0;
		restNz = 1'b0;
		for (int i = 0; i < `DFP_PROD_DIGITS; i++) begin
			if ((i + 1) == int'(shift))
				firstDrop = product[4*i +: 4];
			if ((i + 1) < int'(shift) && product[4*i +: 4] != 4'd0)
				restNz = 1'b1;
		end
	end

	assign dropNz = (firstDrop != 4'd0) || restNz;

	// ----------------------------------------------------------------------
	// rounding
	// ----------------------------------------------------------------------

	always_comb begin
		case (rmQ)
			dfpPkg::rmHalfUp: roundUp = (firstDrop >= 4'd5);
			// ties go to the even kept digit
			dfpPkg::rmHalfEven: roundUp = (firstDrop > 4'd5)
				|| (firstDrop == 4'd5 && (restNz || kept[0]));
			default: roundUp = 1'b0;
		endcase
	end

	// decimal increment of the kept digits
	always_comb begin
		incCarry = roundUp;
		for (int i = 0; i < `DFP_DIGITS; i++) begin
			if (incCarry && kept[4*i +: 4] == 4'd9) begin
				incSum[4*i +: 4] = 4'd0;
			end else begin
				incSum[4*i +: 4] = kept[4*i +: 4] + {3'b0, incCarry};
				incCarry = 1'b0;
			end
		end
	end

	// 999999 rounded up becomes 100000 one place higher
	assign coefOut = incCarry ? `DFP_COEF_W'(24'h100000) : incSum;
	assign shiftTot = shift + {2'b0, incCarry};
	assign expAdj = $signed({expSum[`DFP_ESUM_W-1], expSum}) + $signed({7'b0, shiftTot});

	// exact zero keeps the ideal exponent, pulled into range
	always_comb begin
		if (expSum < 0)
			zeroExp = '0;
		else if (expSum > `DFP_EXP_MAX)
			zeroExp = `DFP_EXP_W'(`DFP_EXP_MAX);
		else
			zeroExp = expSum[`DFP_EXP_W-1:0];
	end

	// ----------------------------------------------------------------------
	// result word and flags
	// ----------------------------------------------------------------------

	always_comb begin
		oNext = '0;
		invNext = 1'b0;
		ovfNext = 1'b0;
		unfNext = 1'b0;
		inxNext = 1'b0;
		oNext.fin.sign = signOut;
		case (special)
			dfpPkg::spQNaN: begin
				oNext.spc.marker = '1;
				oNext.spc.kind = 2'b10;
				oNext.spc.payload = nanPayload;
				invNext = invalidIn;
			end
			dfpPkg::spInf: begin
				// kind 00 and zero payload
				oNext.spc.marker = '1;
			end
			dfpPkg::spZero: begin
				oNext.fin.exp = zeroExp;
			end
			default: begin
				if (expAdj > `DFP_EXP_MAX) begin
					oNext.spc.marker = '1;
					ovfNext = 1'b1;
					inxNext = 1'b1;
				end else if (expAdj < 0 && coefOut != '0) begin
					// flush to zero at exponent 0
					unfNext = 1'b1;
					inxNext = 1'b1;
				end else begin
					oNext.fin.exp = expAdj[`DFP_EXP_W-1:0];
					oNext.fin.coef = coefOut;
					inxNext = (shift != 3'd0) && dropNz;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			done <= 1'b0;
			invalid <= 1'b0;
			overflow <= 1'b0;
			underflow <= 1'b0;
			inexact <= 1'b0;
		end else begin
			done <= prodValid;
			if (prodValid) begin
				invalid <= invNext;
				overflow <= ovfNext;
				underflow <= unfNext;
				inexact <= inxNext;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (prodValid)
			o <= oNext;
	end

	donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
		else $error("done held longer than one cycle");

endmodule

//--- files.f
+incdir+.
dfpPkg.sv
dfpDecode.sv
bcdMulSerial.sv
dfpRound.sv
dfpMulTop.sv
dfpMulTb.sv
